/* logic/asic_audio_defs.svh */
`ifndef ASIC_AUDIO_DEFS_SVH
`define ASIC_AUDIO_DEFS_SVH

// Number of sound-effect channels
`define ASIC_AUDIO_NUM_SFX 4

// Fixed register map, low address byte only
`define REG_VOLUME_L 8'h40
`define REG_VOLUME_R 8'h41
`define REG_TONE_L   8'h42
`define REG_TONE_R   8'h43

// Effect channel register groups
`define REG_SFX_BASE   8'h46
`define REG_SFX_STRIDE 5

// Offsets inside one effect channel group
`define SFX_OFS_VOLUME 0
`define SFX_OFS_FREQ   1
`define SFX_OFS_PAN    3
// Only data bit 0 is kept
`define SFX_OFS_ACTIVE 4

// Full-scale level for waves and pan
`define LEVEL_FULL 8'hFF

`endif

/* logic/asic_audio_pkg.sv */
`default_nettype none

`include "asic_audio_defs.svh"

package asic_audio_pkg;

    // One audio sample or one contribution to the mix
    typedef logic [7:0] sample_t;

    // Volume, tone threshold, frequency step or pan
    typedef logic [7:0] level_t;

    // Phase counter value, wraps at 256
    typedef logic [7:0] phase_t;

    // Register offset from the low address byte
    typedef logic [7:0] reg_addr_t;

    // One flag per effect channel
    typedef logic [`ASIC_AUDIO_NUM_SFX-1:0] chan_mask_t;

endpackage

`default_nettype wire

/* logic/asic_audio_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "asic_audio_defs.svh"

module asic_audio_top import asic_audio_pkg::*; (
    input  wire logic    clk_sys,
    input  wire logic    reset,
    input  wire logic    gx4000_mode,

    // CPU register port
    input  wire logic    [15:0] cpu_addr,
    input  wire level_t  cpu_data,
    input  wire logic    cpu_wr,

    // Computer audio in
    input  wire sample_t cpc_audio_l,
    input  wire sample_t cpc_audio_r,

    output sample_t      audio_l,
    output sample_t      audio_r,
    output chan_mask_t   audio_status
);

    sample_t tone_out_l;
    sample_t tone_out_r;
    sample_t sfx_l [`ASIC_AUDIO_NUM_SFX];
    sample_t sfx_r [`ASIC_AUDIO_NUM_SFX];

    // Settings bus from the register block
    audio_ctrl_if ctrl ();

    audio_regs u_regs (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .gx4000_mode  (gx4000_mode),
        .cpu_addr     (cpu_addr),
        .cpu_data     (cpu_data),
        .cpu_wr       (cpu_wr),
        .ctrl         (ctrl.regs),
        .audio_status (audio_status)
    );

    tone_gen u_tone (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .ctrl       (ctrl.tone),
        .tone_out_l (tone_out_l),
        .tone_out_r (tone_out_r)
    );

    // One effect channel per register group
    for (genvar g = 0; g < `ASIC_AUDIO_NUM_SFX; g++) begin : g_sfx
        sfx_channel #(
            .CHANNEL (g)
        ) u_sfx (
            .clk_sys   (clk_sys),
            .reset     (reset),
            .ctrl      (ctrl.sfx),
            .sfx_out_l (sfx_l[g]),
            .sfx_out_r (sfx_r[g])
        );
    end

    audio_mixer u_mixer (
        .ctrl        (ctrl.mix),
        .cpc_audio_l (cpc_audio_l),
        .cpc_audio_r (cpc_audio_r),
        .tone_out_l  (tone_out_l),
        .tone_out_r  (tone_out_r),
        .sfx_l       (sfx_l),
        .sfx_r       (sfx_r),
        .audio_l     (audio_l),
        .audio_r     (audio_r)
    );

endmodule

`default_nettype wire

/* logic/audio_ctrl_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "asic_audio_defs.svh"

interface audio_ctrl_if import asic_audio_pkg::*; ();

    // Copy of gx4000_mode, gates all phase counters
    logic run;

    // Per-side settings
    level_t volume_l;
    level_t volume_r;
    level_t tone_l;
    level_t tone_r;

    // Effect channel settings, indexed by channel
    level_t sfx_volume [`ASIC_AUDIO_NUM_SFX];
    level_t sfx_freq [`ASIC_AUDIO_NUM_SFX];
    level_t sfx_pan [`ASIC_AUDIO_NUM_SFX];
    chan_mask_t sfx_active;

    // Register block owns every setting
    modport regs (
        output run,
        output volume_l,
        output volume_r,
        output tone_l,
        output tone_r,
        output sfx_volume,
        output sfx_freq,
        output sfx_pan,
        output sfx_active
    );

    modport tone (
        input run,
        input tone_l,
        input tone_r,
        input volume_l,
        input volume_r
    );

    modport sfx (
        input run,
        input sfx_volume,
        input sfx_freq,
        input sfx_pan,
        input sfx_active
    );

    modport mix (
        input volume_l,
        input volume_r
    );

endinterface

`default_nettype wire

/* logic/audio_mixer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "asic_audio_defs.svh"

module audio_mixer import asic_audio_pkg::*; (
    audio_ctrl_if.mix  ctrl,
    input  wire sample_t cpc_audio_l,
    input  wire sample_t cpc_audio_r,
    input  wire sample_t tone_out_l,
    input  wire sample_t tone_out_r,
    input  wire sample_t sfx_l [`ASIC_AUDIO_NUM_SFX],
    input  wire sample_t sfx_r [`ASIC_AUDIO_NUM_SFX],
    output sample_t      audio_l,
    output sample_t      audio_r
);

    logic [15:0] cpc_prod_l;
    logic [15:0] cpc_prod_r;
    sample_t     cpc_scaled_l;
    sample_t     cpc_scaled_r;

    // Computer audio through the per-side volume
    assign cpc_prod_l = 16'(cpc_audio_l) * 16'(ctrl.volume_l);
    assign cpc_prod_r = 16'(cpc_audio_r) * 16'(ctrl.volume_r);

    assign cpc_scaled_l = sample_t'(cpc_prod_l >> 8);
    assign cpc_scaled_r = sample_t'(cpc_prod_r >> 8);

    // Per-side sum wraps at 256
    always_comb begin
        audio_l = sample_t'(cpc_scaled_l + tone_out_l);
        audio_r = sample_t'(cpc_scaled_r + tone_out_r);
        for (int i = 0; i < `ASIC_AUDIO_NUM_SFX; i++) begin
            audio_l = sample_t'(audio_l + sfx_l[i]);
            audio_r = sample_t'(audio_r + sfx_r[i]);
        end
    end

endmodule

`default_nettype wire

/* logic/audio_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "asic_audio_defs.svh"

module audio_regs import asic_audio_pkg::*; (
    input  wire logic   clk_sys,
    input  wire logic   reset,
    input  wire logic   gx4000_mode,
    input  wire logic   [15:0] cpu_addr,
    input  wire level_t cpu_data,
    input  wire logic   cpu_wr,
    audio_ctrl_if.regs  ctrl,
    output chan_mask_t  audio_status
);

    reg_addr_t addr;
    logic      wr_en;

    // Address of one register inside an effect channel group
    function automatic reg_addr_t sfx_reg(input int ch, input int ofs);
        return reg_addr_t'(`REG_SFX_BASE + ch * `REG_SFX_STRIDE + ofs);
    endfunction

    // High address byte is not decoded
    assign addr  = reg_addr_t'(cpu_addr[7:0]);
    assign wr_en = cpu_wr && gx4000_mode;

    assign ctrl.run = gx4000_mode;

    // Fixed per-side registers
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ctrl.volume_l <= '0;
            ctrl.volume_r <= '0;
            ctrl.tone_l   <= '0;
            ctrl.tone_r   <= '0;
        end else if (wr_en) begin
            case (addr)
                `REG_VOLUME_L: ctrl.volume_l <= cpu_data;
                `REG_VOLUME_R: ctrl.volume_r <= cpu_data;
                `REG_TONE_L:   ctrl.tone_l   <= cpu_data;
                `REG_TONE_R:   ctrl.tone_r   <= cpu_data;
                default: ;
            endcase
        end
    end

    // Effect channel groups, one stride apart
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int i = 0; i < `ASIC_AUDIO_NUM_SFX; i++) begin
                ctrl.sfx_volume[i] <= '0;
                ctrl.sfx_freq[i]   <= '0;
                ctrl.sfx_pan[i]    <= '0;
            end
            ctrl.sfx_active <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < `ASIC_AUDIO_NUM_SFX; i++) begin
                if (addr == sfx_reg(i, `SFX_OFS_VOLUME)) begin
                    ctrl.sfx_volume[i] <= cpu_data;
                end
                if (addr == sfx_reg(i, `SFX_OFS_FREQ)) begin
                    ctrl.sfx_freq[i] <= cpu_data;
                end
                if (addr == sfx_reg(i, `SFX_OFS_PAN)) begin
                    ctrl.sfx_pan[i] <= cpu_data;
                end
                if (addr == sfx_reg(i, `SFX_OFS_ACTIVE)) begin
                    ctrl.sfx_active[i] <= cpu_data[0];
                end
            end
        end
    end

    // Status mirrors the active flags, channel 0 in the top bit
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            audio_status <= '0;
        end else begin
            for (int i = 0; i < `ASIC_AUDIO_NUM_SFX; i++) begin
                audio_status[`ASIC_AUDIO_NUM_SFX-1-i] <= ctrl.sfx_active[i];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/sfx_channel.sv */
`timescale 1ns/1ns
`default_nettype none

`include "asic_audio_defs.svh"

module sfx_channel import asic_audio_pkg::*; #(
    parameter int CHANNEL = 0
) (
    input  wire logic clk_sys,
    input  wire logic reset,
    audio_ctrl_if.sfx ctrl,
    output sample_t   sfx_out_l,
    output sample_t   sfx_out_r
);

    phase_t      phase;
    level_t      volume;
    level_t      freq;
    level_t      pan;
    level_t      pan_inv;
    logic        active;
    sample_t     wave;
    logic [23:0] prod_l;
    logic [23:0] prod_r;

    // This channel's slice of the shared settings
    assign volume = ctrl.sfx_volume[CHANNEL];
    assign freq   = ctrl.sfx_freq[CHANNEL];
    assign pan    = ctrl.sfx_pan[CHANNEL];
    assign active = ctrl.sfx_active[CHANNEL];

    // Phase accumulator, frozen when idle or out of console mode
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            phase <= '0;
        end else if (ctrl.run && active) begin
            phase <= phase_t'(phase + freq);
        end
    end

    // Duty follows the frequency step
    assign wave = (phase < freq) ? sample_t'(`LEVEL_FULL) : '0;

    // Pan zero is hard left, full scale is hard right
    assign pan_inv = level_t'(`LEVEL_FULL - pan);

    assign prod_l = 24'(wave) * 24'(volume) * 24'(pan_inv);
    assign prod_r = 24'(wave) * 24'(volume) * 24'(pan);

    assign sfx_out_l = sample_t'(prod_l >> 16);
    assign sfx_out_r = sample_t'(prod_r >> 16);

endmodule

`default_nettype wire

/* logic/tone_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "asic_audio_defs.svh"

module tone_gen import asic_audio_pkg::*; (
    input  wire logic  clk_sys,
    input  wire logic  reset,
    audio_ctrl_if.tone ctrl,
    output sample_t    tone_out_l,
    output sample_t    tone_out_r
);

    phase_t          phase;
    sample_t         wave_l;
    sample_t         wave_r;
    logic [15:0]     prod_l;
    logic [15:0]     prod_r;

    // One free-running phase shared by both sides
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            phase <= '0;
        end else if (ctrl.run) begin
            phase <= phase_t'(phase + 1'b1);
        end
    end

    // Square wave, high while phase is under the tone setting
    assign wave_l = (phase < ctrl.tone_l) ? sample_t'(`LEVEL_FULL) : '0;
    assign wave_r = (phase < ctrl.tone_r) ? sample_t'(`LEVEL_FULL) : '0;

    // Volume scaling keeps the upper byte
    assign prod_l = 16'(wave_l) * 16'(ctrl.volume_l);
    assign prod_r = 16'(wave_r) * 16'(ctrl.volume_r);

    assign tone_out_l = sample_t'(prod_l >> 8);
    assign tone_out_r = sample_t'(prod_r >> 8);

endmodule

`default_nettype wire

/* tb/asic_audio_tb_checks.svh */
`ifndef ASIC_AUDIO_TB_CHECKS_SVH
`define ASIC_AUDIO_TB_CHECKS_SVH

// Report the failure and stop the run
task automatic stop_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first error");
endtask

// Audio output sample
task automatic check_sample(input string name, input sample_t expected,
                            input sample_t actual);
    if (actual !== expected) begin
        stop_run($sformatf("ERR %s expected 0x%02h actual 0x%02h", name, expected, actual));
    end
endtask

// Status flags, one bit per effect channel
task automatic check_mask(input string name, input chan_mask_t expected,
                          input chan_mask_t actual);
    if (actual !== expected) begin
        stop_run($sformatf("ERR %s expected %b actual %b", name, expected, actual));
    end
endtask

// Number of cycles a wave was high within one period
task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
        stop_run($sformatf("ERR %s expected %0d actual %0d", name, expected, actual));
    end
endtask

`endif

/* tb/asic_audio_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "asic_audio_defs.svh"

module asic_audio_tb import asic_audio_pkg::*; ();

    localparam int NUM_TESTS    = 17;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = NUM_TESTS * 300 + RESET_CYCLES;

    // Test kinds
    localparam int K_RESET     = 0;
    localparam int K_PASS      = 1;
    localparam int K_TONE_L    = 2;
    localparam int K_TONE_R    = 3;
    localparam int K_SFX       = 4;
    localparam int K_STATUS    = 5;
    localparam int K_GATE_VOL  = 6;
    localparam int K_GATE_TONE = 7;

    logic        clk_sys;
    logic        reset;
    logic        gx4000_mode;
    logic [15:0] cpu_addr;
    level_t      cpu_data;
    logic        cpu_wr;
    sample_t     cpc_audio_l;
    sample_t     cpc_audio_r;
    sample_t     audio_l;
    sample_t     audio_r;
    chan_mask_t  audio_status;

    // Test table with one array per column
    string       t_name [NUM_TESTS];
    int          t_kind [NUM_TESTS];
    level_t      t_a [NUM_TESTS];
    level_t      t_b [NUM_TESTS];
    level_t      t_c [NUM_TESTS];
    level_t      t_d [NUM_TESTS];
    sample_t     t_cpc_l [NUM_TESTS];
    sample_t     t_cpc_r [NUM_TESTS];
    sample_t     t_exp_l [NUM_TESTS];
    sample_t     t_exp_r [NUM_TESTS];
    int          t_exp_n [NUM_TESTS];
    chan_mask_t  t_exp_mask [NUM_TESTS];

    int          n_entries;
    int          cycles = 0;
    logic [7:0]  lfsr_state;

    `include "asic_audio_tb_checks.svh"

    asic_audio_top uut (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .gx4000_mode  (gx4000_mode),
        .cpu_addr     (cpu_addr),
        .cpu_data     (cpu_data),
        .cpu_wr       (cpu_wr),
        .cpc_audio_l  (cpc_audio_l),
        .cpc_audio_r  (cpc_audio_r),
        .audio_l      (audio_l),
        .audio_r      (audio_r),
        .audio_status (audio_status)
    );

    initial begin
        clk_sys = 1'b0;
        forever begin
            #20 clk_sys = ~clk_sys;
        end
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_run("Timeout: the test table did not finish within the cycle limit");
        end
    end

    // Fibonacci LFSR with taps from x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_byte(output logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            value      = {value[6:0], lfsr_state[7]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Value times volume keeps the upper byte
    function automatic sample_t scale_level(input logic [7:0] x, input logic [7:0] vol);
        logic [15:0] p;
        p = {8'h00, x} * {8'h00, vol};
        return p[15:8];
    endfunction

    // Full-scale wave times volume times pan share
    function automatic sample_t pan_level(input logic [7:0] vol, input logic [7:0] share);
        logic [23:0] p;
        p = 24'hFF * {16'h0000, vol} * {16'h0000, share};
        return p[23:16];
    endfunction

    // Channel 0 lands in the top status bit
    function automatic chan_mask_t status_of(input chan_mask_t raw);
        return {raw[0], raw[1], raw[2], raw[3]};
    endfunction

    task automatic add_entry(input string name, input int kind, input level_t a,
                             input level_t b, input level_t c, input level_t d,
                             input sample_t cpc_l, input sample_t cpc_r);
        t_name[n_entries]     = name;
        t_kind[n_entries]     = kind;
        t_a[n_entries]        = a;
        t_b[n_entries]        = b;
        t_c[n_entries]        = c;
        t_d[n_entries]        = d;
        t_cpc_l[n_entries]    = cpc_l;
        t_cpc_r[n_entries]    = cpc_r;
        t_exp_l[n_entries]    = 8'h00;
        t_exp_r[n_entries]    = 8'h00;
        t_exp_n[n_entries]    = 0;
        t_exp_mask[n_entries] = '0;
        case (kind)
            // Only volumes a and b land since c and d are written out of console mode
            K_PASS, K_GATE_VOL: begin
                t_exp_l[n_entries] = scale_level(cpc_l, a);
                t_exp_r[n_entries] = scale_level(cpc_r, b);
            end
            K_TONE_L, K_TONE_R: begin
                t_exp_l[n_entries] = scale_level(`LEVEL_FULL, `LEVEL_FULL);
                t_exp_n[n_entries] = int'(a);
            end
            K_SFX: begin
                t_exp_l[n_entries] = pan_level(c, `LEVEL_FULL - d);
                t_exp_r[n_entries] = pan_level(c, d);
                t_exp_n[n_entries] = int'(b);
            end
            K_STATUS: t_exp_mask[n_entries] = status_of(a[3:0]);
            K_GATE_TONE: t_exp_l[n_entries] = scale_level(`LEVEL_FULL, `LEVEL_FULL);
            default: ;
        endcase
        n_entries++;
    endtask

    // Rising edge plus the stimulus offset
    task automatic next_cycle();
        @(posedge clk_sys);
        #5;
    endtask

    // High address byte is arbitrary
    task automatic write_reg(input logic [7:0] addr, input level_t data);
        cpu_addr = {8'h68, addr};
        cpu_data = data;
        cpu_wr   = 1'b1;
        next_cycle();
        cpu_wr   = 1'b0;
    endtask

    task automatic write_sfx(input int ch, input int ofs, input level_t data);
        write_reg(8'(`REG_SFX_BASE + ch * `REG_SFX_STRIDE + ofs), data);
    endtask

    // Silence the tones and all effect channels
    task automatic quiet_all();
        write_reg(`REG_TONE_L, 8'h00);
        write_reg(`REG_TONE_R, 8'h00);
        for (int ch = 0; ch < `ASIC_AUDIO_NUM_SFX; ch++) begin
            write_sfx(ch, `SFX_OFS_ACTIVE, 8'h00);
            write_sfx(ch, `SFX_OFS_VOLUME, 8'h00);
        end
        cpc_audio_l = 8'h00;
        cpc_audio_r = 8'h00;
    endtask

    task automatic run_entry(input int i);
        int      count;
        sample_t on_val;
        sample_t off_val;
        sample_t held;
        count = 0;
        case (t_kind[i])
            K_RESET: begin
                cpc_audio_l = t_cpc_l[i];
                cpc_audio_r = t_cpc_r[i];
                next_cycle();
                check_sample({t_name[i], " left"}, 8'h00, audio_l);
                check_sample({t_name[i], " right"}, 8'h00, audio_r);
                check_mask(t_name[i], t_exp_mask[i], audio_status);
            end
            K_PASS, K_GATE_VOL: begin
                quiet_all();
                write_reg(`REG_VOLUME_L, t_a[i]);
                write_reg(`REG_VOLUME_R, t_b[i]);
                if (t_kind[i] == K_GATE_VOL) begin
                    gx4000_mode = 1'b0;
                    write_reg(`REG_VOLUME_L, t_c[i]);
                    write_reg(`REG_VOLUME_R, t_d[i]);
                end
                cpc_audio_l = t_cpc_l[i];
                cpc_audio_r = t_cpc_r[i];
                next_cycle();
                check_sample({t_name[i], " left"}, t_exp_l[i], audio_l);
                check_sample({t_name[i], " right"}, t_exp_r[i], audio_r);
                gx4000_mode = 1'b1;
            end
            K_TONE_L, K_TONE_R: begin
                quiet_all();
                write_reg(`REG_VOLUME_L, `LEVEL_FULL);
                write_reg(`REG_VOLUME_R, `LEVEL_FULL);
                write_reg((t_kind[i] == K_TONE_L) ? `REG_TONE_L : `REG_TONE_R, t_a[i]);
                // One full phase period
                for (int n = 0; n < 256; n++) begin
                    on_val  = (t_kind[i] == K_TONE_L) ? audio_l : audio_r;
                    off_val = (t_kind[i] == K_TONE_L) ? audio_r : audio_l;
                    check_sample({t_name[i], " silent side"}, 8'h00, off_val);
                    if (on_val !== 8'h00) begin
                        check_sample(t_name[i], t_exp_l[i], on_val);
                        count++;
                    end
                    next_cycle();
                end
                check_count({t_name[i], " high cycles"}, t_exp_n[i], count);
            end
            K_SFX: begin
                quiet_all();
                write_sfx(int'(t_a[i]), `SFX_OFS_FREQ, t_b[i]);
                write_sfx(int'(t_a[i]), `SFX_OFS_VOLUME, t_c[i]);
                write_sfx(int'(t_a[i]), `SFX_OFS_PAN, t_d[i]);
                write_sfx(int'(t_a[i]), `SFX_OFS_ACTIVE, 8'h01);
                // Odd step visits every phase once in 256 cycles
                for (int n = 0; n < 256; n++) begin
                    if (audio_l !== 8'h00 || audio_r !== 8'h00) begin
                        check_sample({t_name[i], " left"}, t_exp_l[i], audio_l);
                        check_sample({t_name[i], " right"}, t_exp_r[i], audio_r);
                        count++;
                    end
                    next_cycle();
                end
                check_count({t_name[i], " high cycles"}, t_exp_n[i], count);
            end
            K_STATUS: begin
                quiet_all();
                next_cycle();
                for (int ch = 0; ch < `ASIC_AUDIO_NUM_SFX - 1; ch++) begin
                    write_sfx(ch, `SFX_OFS_ACTIVE, {7'h00, t_a[i][ch]});
                end
                next_cycle();
                write_sfx(`ASIC_AUDIO_NUM_SFX - 1, `SFX_OFS_ACTIVE, {7'h00, t_a[i][3]});
                // Last flag not yet in status
                check_mask({t_name[i], " before"}, status_of(t_a[i][3:0] & 4'b0111),
                           audio_status);
                next_cycle();
                check_mask(t_name[i], t_exp_mask[i], audio_status);
            end
            K_GATE_TONE: begin
                quiet_all();
                write_reg(`REG_VOLUME_L, `LEVEL_FULL);
                write_reg(`REG_TONE_L, t_a[i]);
                // The tone rises only where the phase wraps to zero
                held = audio_l;
                next_cycle();
                while (held !== 8'h00 || audio_l === 8'h00) begin
                    held = audio_l;
                    next_cycle();
                end
                // Freeze at phase zero, a running phase would leave the short high part
                gx4000_mode = 1'b0;
                check_sample({t_name[i], " level"}, t_exp_l[i], audio_l);
                held = audio_l;
                for (int n = 0; n < 20; n++) begin
                    next_cycle();
                    check_sample(t_name[i], held, audio_l);
                end
                gx4000_mode = 1'b1;
            end
            default: stop_run($sformatf("Unknown test kind in entry %0d", i));
        endcase
    endtask

    initial begin
        logic [7:0] r0;
        logic [7:0] r1;
        logic [7:0] r2;
        logic [7:0] r3;
        lfsr_state  = 8'd94;
        n_entries   = 0;
        reset       = 1'b1;
        gx4000_mode = 1'b1;
        cpu_addr    = '0;
        cpu_data    = '0;
        cpu_wr      = 1'b0;
        cpc_audio_l = 8'h00;
        cpc_audio_r = 8'h00;

        add_entry("reset_zero", K_RESET, 8'h00, 8'h00, 8'h00, 8'h00, 8'hA5, 8'h5A);
        for (int k = 0; k < 4; k++) begin
            draw_byte(r0);
            draw_byte(r1);
            draw_byte(r2);
            draw_byte(r3);
            add_entry($sformatf("pass_%0d", k), K_PASS, r0, r1, 8'h00, 8'h00, r2, r3);
        end
        add_entry("tone_l_40", K_TONE_L, 8'h40, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        add_entry("tone_l_9c", K_TONE_L, 8'h9C, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        add_entry("tone_r_21", K_TONE_R, 8'h21, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        add_entry("tone_r_ff", K_TONE_R, 8'hFF, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        // Channel, frequency, volume, pan
        add_entry("sfx_ch0", K_SFX, 8'd0, 8'h55, 8'h80, 8'h40, 8'h00, 8'h00);
        add_entry("sfx_ch1", K_SFX, 8'd1, 8'h07, 8'h40, 8'h80, 8'h00, 8'h00);
        add_entry("sfx_ch2", K_SFX, 8'd2, 8'h1B, 8'hFF, 8'h00, 8'h00, 8'h00);
        add_entry("sfx_ch3", K_SFX, 8'd3, 8'hC3, 8'h60, 8'hFF, 8'h00, 8'h00);
        add_entry("status_b", K_STATUS, 8'h0B, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        add_entry("status_e", K_STATUS, 8'h0E, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        add_entry("gate_volume", K_GATE_VOL, 8'h80, 8'h40, 8'hFF, 8'hFF, 8'hC8, 8'h64);
        add_entry("gate_tone", K_GATE_TONE, 8'h08, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);

        repeat (RESET_CYCLES) begin
            next_cycle();
        end
        reset = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
+incdir+tb
logic/asic_audio_pkg.sv
logic/audio_ctrl_if.sv
logic/audio_regs.sv
logic/tone_gen.sv
logic/sfx_channel.sv
logic/audio_mixer.sv
logic/asic_audio_top.sv
tb/asic_audio_tb.sv
